/* logic/kiwi_defs.svh */
`ifndef KIWI_DEFS_SVH
`define KIWI_DEFS_SVH

// data path and pc width
`define KIWI_XLEN 64

// architectural integer registers
`define KIWI_NREGS 32

// bits needed to index a register
`define KIWI_REG_W 5

`endif

/* logic/kiwi_pkg.sv */
`include "kiwi_defs.svh"

package kiwi_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_BEQ,
        OP_BNE,
        OP_ILLEGAL
    } kiwi_op_e;

    typedef struct packed {
        logic [`KIWI_XLEN-1:0] pc;
        logic [31:0]           inst;
    } fetch_pkt_t;

    // unused source indices decode to x0
    typedef struct packed {
        kiwi_op_e              op;
        logic [`KIWI_REG_W-1:0] rs1;
        logic [`KIWI_REG_W-1:0] rs2;
        logic [`KIWI_REG_W-1:0] rd;
        logic                  rd_we;
        logic                  is_branch;
        logic [`KIWI_XLEN-1:0] imm;
        logic [`KIWI_XLEN-1:0] pc;
    } dec_op_t;

    typedef struct packed {
        dec_op_t               dec;
        logic [`KIWI_XLEN-1:0] rs1_val;
        logic [`KIWI_XLEN-1:0] rs2_val;
    } exe_op_t;

    typedef struct packed {
        logic                  valid;
        logic [`KIWI_REG_W-1:0] rd;
        logic [`KIWI_XLEN-1:0] value;
    } wb_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [`KIWI_XLEN-1:0] pc;
    } redirect_t;

endpackage

/* logic/kiwi_decoder.sv */
`timescale 1ns/100ps
`include "kiwi_defs.svh"

module kiwi_decoder import kiwi_pkg::*; (
    input  fetch_pkt_t inst_i,
    output dec_op_t    op_o
);

    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [31:0]            word;
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`KIWI_REG_W-1:0] rd;
    logic [`KIWI_XLEN-1:0]  imm_i;
    logic [`KIWI_XLEN-1:0]  imm_b;
    kiwi_op_e               op;

    assign word   = inst_i.inst;
    assign opcode = word[6:0];
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];
    assign rd     = word[11:7];

    assign imm_i = {{52{word[31]}}, word[31:20]};
    assign imm_b = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};

    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            OPC_REG: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_100: op = OP_XOR;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_111: op = OP_AND;
                    default:         op = OP_ILLEGAL;
                endcase
            end
            OPC_IMM: begin
                if (funct3 == 3'b000) begin
                    op = OP_ADDI;
                end
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op = OP_BNE;
                end
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    // only the fields an operation really uses are filled in
    always_comb begin
        op_o    = '0;
        op_o.op = op;
        op_o.pc = inst_i.pc;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                op_o.rs1   = word[19:15];
                op_o.rs2   = word[24:20];
                op_o.rd    = rd;
                op_o.rd_we = (rd != '0);
            end
            OP_ADDI: begin
                op_o.rs1   = word[19:15];
                op_o.rd    = rd;
                op_o.rd_we = (rd != '0);
                op_o.imm   = imm_i;
            end
            OP_BEQ, OP_BNE: begin
                op_o.rs1       = word[19:15];
                op_o.rs2       = word[24:20];
                op_o.is_branch = 1'b1;
                op_o.imm       = imm_b;
            end
            default: ;
        endcase
    end

endmodule

/* logic/kiwi_regfile.sv */
`timescale 1ns/100ps
`include "kiwi_defs.svh"

module kiwi_regfile import kiwi_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [`KIWI_REG_W-1:0] rs1_i,
    input  logic [`KIWI_REG_W-1:0] rs2_i,
    output logic [`KIWI_XLEN-1:0]  rs1_data_o,
    output logic [`KIWI_XLEN-1:0]  rs2_data_o,
    input  wb_pkt_t                wb_i
);

    // x0 has no storage
    logic [`KIWI_XLEN-1:0] regs [1:`KIWI_NREGS-1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < `KIWI_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    // same-cycle write is not forwarded
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* logic/kiwi_alu.sv */
`timescale 1ns/100ps
`include "kiwi_defs.svh"

module kiwi_alu import kiwi_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    issue_i,
    input  logic    kill_i,
    input  exe_op_t op_i,
    output wb_pkt_t wb_o
);

    logic                   s1_valid;
    exe_op_t                s1_op;
    logic [`KIWI_XLEN-1:0]  result;
    logic                   wb_valid_q;
    logic [`KIWI_REG_W-1:0] wb_rd_q;
    logic [`KIWI_XLEN-1:0]  wb_value_q;

    // stage 1 captures everything that is not a branch or illegal
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_i && !op_i.dec.is_branch && op_i.dec.op != OP_ILLEGAL;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            s1_op <= op_i;
        end
    end

    always_comb begin
        case (s1_op.dec.op)
            OP_ADD:  result = s1_op.rs1_val + s1_op.rs2_val;
            OP_SUB:  result = s1_op.rs1_val - s1_op.rs2_val;
            OP_AND:  result = s1_op.rs1_val & s1_op.rs2_val;
            OP_OR:   result = s1_op.rs1_val | s1_op.rs2_val;
            OP_XOR:  result = s1_op.rs1_val ^ s1_op.rs2_val;
            OP_ADDI: result = s1_op.rs1_val + s1_op.dec.imm;
            default: result = '0;
        endcase
    end

    // a killed stage-1 op never reaches stage 2
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= s1_valid && !kill_i && s1_op.dec.rd_we;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_q    <= s1_op.dec.rd;
        wb_value_q <= result;
    end

    assign wb_o = '{valid: wb_valid_q, rd: wb_rd_q, value: wb_value_q};

endmodule

/* logic/kiwi_beu.sv */
`timescale 1ns/100ps
`include "kiwi_defs.svh"

module kiwi_beu import kiwi_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      issue_i,
    input  logic      kill_i,
    input  exe_op_t   op_i,
    output redirect_t redirect_o
);

    logic                  s1_valid;
    exe_op_t               s1_op;
    logic                  equal;
    logic                  taken;
    logic                  redir_valid_q;
    logic [`KIWI_XLEN-1:0] redir_pc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_i && op_i.dec.is_branch;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            s1_op <= op_i;
        end
    end

    assign equal = (s1_op.rs1_val == s1_op.rs2_val);
    // beq on equal, bne otherwise
    assign taken = (s1_op.dec.op == OP_BEQ) ? equal : !equal;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            redir_valid_q <= 1'b0;
        end else begin
            redir_valid_q <= s1_valid && !kill_i && taken;
        end
    end

    always_ff @(posedge clk_i) begin
        redir_pc_q <= s1_op.dec.pc + s1_op.dec.imm;
    end

    assign redirect_o = '{valid: redir_valid_q, pc: redir_pc_q};

endmodule

/* logic/kiwi_scoreboard.sv */
`timescale 1ns/100ps
`include "kiwi_defs.svh"

module kiwi_scoreboard import kiwi_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  dec_op_t   op_i,
    output logic      inst_ready_o,
    output logic      issue_o,
    output logic      kill_o,
    input  wb_pkt_t   wb_i,
    input  redirect_t redirect_i
);

    logic [`KIWI_NREGS-1:0] busy;
    logic [`KIWI_NREGS-1:0] busy_nxt;
    logic                   raw_hazard;
    logic                   waw_hazard;
    // what sits in execute stage 1
    logic                   s1_we;
    logic [`KIWI_REG_W-1:0] s1_rd;

    assign raw_hazard = busy[op_i.rs1] || busy[op_i.rs2];
    // an older write to the same rd would free it too early
    assign waw_hazard = op_i.rd_we && busy[op_i.rd];

    assign inst_ready_o = !raw_hazard && !waw_hazard && !redirect_i.valid;
    assign issue_o      = inst_valid_i && inst_ready_o;

    // wrong-path op behind a taken branch
    assign kill_o = redirect_i.valid;

    always_comb begin
        busy_nxt = busy;
        if (wb_i.valid) begin
            busy_nxt[wb_i.rd] = 1'b0;
        end
        if (redirect_i.valid && s1_we) begin
            busy_nxt[s1_rd] = 1'b0;
        end
        if (issue_o && op_i.rd_we) begin
            busy_nxt[op_i.rd] = 1'b1;
        end
        busy_nxt[0] = 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy  <= '0;
            s1_we <= 1'b0;
        end else begin
            busy  <= busy_nxt;
            s1_we <= issue_o && op_i.rd_we;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_rd <= op_i.rd;
    end

endmodule

/* logic/kiwi_core.sv */
`timescale 1ns/100ps
`include "kiwi_defs.svh"

module kiwi_core import kiwi_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       inst_valid_i,
    input  fetch_pkt_t inst_i,
    output logic       inst_ready_o,
    output wb_pkt_t    wb_o,
    output redirect_t  redirect_o
);

    dec_op_t               dec_op;
    exe_op_t               exe_op;
    logic [`KIWI_XLEN-1:0] rs1_data;
    logic [`KIWI_XLEN-1:0] rs2_data;
    logic                  issue;
    logic                  kill;

    assign exe_op = '{dec: dec_op, rs1_val: rs1_data, rs2_val: rs2_data};

    kiwi_decoder u_decoder (
        .inst_i (inst_i),
        .op_o   (dec_op)
    );

    kiwi_regfile u_regfile (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_i      (dec_op.rs1),
        .rs2_i      (dec_op.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_o)
    );

    kiwi_scoreboard u_scoreboard (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .op_i         (dec_op),
        .inst_ready_o (inst_ready_o),
        .issue_o      (issue),
        .kill_o       (kill),
        .wb_i         (wb_o),
        .redirect_i   (redirect_o)
    );

    // both units see every issue and pick their own ops
    kiwi_alu u_alu (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .issue_i (issue),
        .kill_i  (kill),
        .op_i    (exe_op),
        .wb_o    (wb_o)
    );

    kiwi_beu u_beu (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .issue_i    (issue),
        .kill_i     (kill),
        .op_i       (exe_op),
        .redirect_o (redirect_o)
    );

endmodule

/* tb/kiwi_clock_gen.sv */
`timescale 1ns/100ps

module kiwi_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held over ten rising edges
    initial begin
        reset_o = 1'b1;
        repeat (10) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

/* tb/kiwi_properties.sv */
`timescale 1ns/100ps

module kiwi_properties import kiwi_pkg::*; (
    input logic      clk_i,
    input logic      reset_i,
    input wb_pkt_t   wb_i,
    input redirect_t redirect_i
);

    // one result port active per cycle
    wb_redirect_apart: assert property (
        @(posedge clk_i) disable iff (reset_i) !(wb_i.valid && redirect_i.valid)
    ) else $error("write-back and redirect are valid in the same cycle");

    // the wrong-path op behind a taken branch never writes back
    no_wb_after_redirect: assert property (
        @(posedge clk_i) disable iff (reset_i) redirect_i.valid |=> !wb_i.valid
    ) else $error("write-back in the cycle after a redirect");

    no_wb_to_x0: assert property (
        @(posedge clk_i) disable iff (reset_i) wb_i.valid |-> wb_i.rd != '0
    ) else $error("write-back targets x0");

endmodule

/* tb/kiwi_tb.sv */
`timescale 1ns/100ps
`include "kiwi_defs.svh"

module kiwi_tb import kiwi_pkg::*; ();

    localparam int CLK_NS = 10;

    logic                  clk;
    logic                  reset;
    logic                  inst_valid;
    fetch_pkt_t            inst;
    logic                  inst_ready;
    wb_pkt_t               wb;
    redirect_t             redirect;
    fetch_pkt_t            stim_q [$];
    wb_pkt_t               exp_wb [$];
    redirect_t             exp_redir [$];
    logic [`KIWI_XLEN-1:0] xreg [`KIWI_NREGS] = '{default: '0};
    logic [`KIWI_XLEN-1:0] next_pc;
    logic                  flush_next = 1'b0;
    logic                  run_done = 1'b0;
    int                    free_at [`KIWI_NREGS] = '{default: 0};
    int                    redir_block = -1;
    int                    edge_cnt = 0;

    kiwi_clock_gen u_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    kiwi_core dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .inst_ready_o (inst_ready),
        .wb_o         (wb),
        .redirect_o   (redirect)
    );

    bind kiwi_core kiwi_properties u_props (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wb_i       (wb_o),
        .redirect_i (redirect_o)
    );

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] r_type_word(input int f7, input int f3, input int rd,
                                                input int rs1, input int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] branch_word(input int f3, input int rs1, input int rs2,
                                                input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
    endfunction

    // 0 illegal, 1 register-register, 2 addi, 3 beq or bne
    function automatic int op_kind(input logic [31:0] w);
        case (w[6:0])
            7'h33: begin
                if (w[31:25] == 7'h00 && w[14:12] inside {3'd0, 3'd4, 3'd6, 3'd7}) begin
                    return 1;
                end
                return (w[31:25] == 7'h20 && w[14:12] == 3'd0) ? 1 : 0;
            end
            7'h13: return (w[14:12] == 3'd0) ? 2 : 0;
            7'h63: return (w[14:13] == 2'b00) ? 3 : 0;
            default: return 0;
        endcase
    endfunction

    // a source is free three edges after its producer was accepted
    function automatic logic ready_model(input logic [31:0] w);
        int   kind;
        int   nxt;
        logic ok;
        kind = op_kind(w);
        nxt  = edge_cnt + 1;
        ok   = (nxt != redir_block);
        if (kind != 0 && free_at[w[19:15]] > nxt) begin
            ok = 1'b0;
        end
        if ((kind == 1 || kind == 3) && free_at[w[24:20]] > nxt) begin
            ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic stop_run(input string why);
        run_done = 1'b1;
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic append_inst(input logic [31:0] w);
        fetch_pkt_t p;
        p.pc    = next_pc;
        p.inst  = w;
        stim_q.push_back(p);
        next_pc = next_pc + 64'd4;
    endtask

    task automatic build_table();
        int f7s [5] = '{0, 32, 0, 0, 0};
        int f3s [5] = '{0, 0, 7, 6, 4};
        next_pc = 64'h1000;
        for (int r = 1; r <= 4; r++) begin
            append_inst(addi_word(r, 0, $urandom));
        end
        for (int k = 0; k < 5; k++) begin
            append_inst(r_type_word(f7s[k], f3s[k], 5 + k, 1 + $urandom % 4, 1 + $urandom % 4));
        end
        // back-to-back dependences
        append_inst(addi_word(10, 5, $urandom));
        append_inst(r_type_word(0, 0, 11, 10, 10));
        append_inst(r_type_word(32, 0, 12, 11, 1));
        // taken beq, wrong-path addi, then target at pc + 16
        append_inst(branch_word(0, 1, 1, 16));
        append_inst(addi_word(13, 0, 85));
        next_pc = next_pc + 64'd8;
        append_inst(addi_word(14, 0, 7));
        // taken bne backwards by 64
        append_inst(branch_word(1, 14, 0, -64));
        append_inst(r_type_word(0, 4, 15, 1, 2));
        next_pc = next_pc - 64'd72;
        append_inst(r_type_word(0, 0, 16, 14, 13));
        append_inst(branch_word(0, 14, 0, 32));
        append_inst(addi_word(17, 14, 1));
        append_inst(branch_word(1, 0, 0, 8));
        // x0 writes and an illegal word
        append_inst(addi_word(0, 1, 5));
        append_inst(r_type_word(0, 0, 18, 0, 2));
        append_inst(32'hffff_ffff);
        append_inst(addi_word(19, 0, -1));
    endtask

    // in-order RV64I model, run for each accepted instruction
    task automatic run_model(input fetch_pkt_t p);
        logic [31:0]           w;
        logic [`KIWI_XLEN-1:0] a;
        logic [`KIWI_XLEN-1:0] b;
        logic [`KIWI_XLEN-1:0] res;
        logic [`KIWI_XLEN-1:0] off;
        logic                  wr;
        wb_pkt_t               wb_e;
        redirect_t             rd_e;
        w   = p.inst;
        a   = xreg[w[19:15]];
        b   = xreg[w[24:20]];
        off = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        wr  = 1'b1;
        res = '0;
        if (w[6:0] == 7'h13 && w[14:12] == 3'd0) begin
            res = a + {{52{w[31]}}, w[31:20]};
        end else begin
            case ({w[31:25], w[14:12], w[6:0]})
                {7'h00, 3'd0, 7'h33}: res = a + b;
                {7'h20, 3'd0, 7'h33}: res = a - b;
                {7'h00, 3'd7, 7'h33}: res = a & b;
                {7'h00, 3'd6, 7'h33}: res = a | b;
                {7'h00, 3'd4, 7'h33}: res = a ^ b;
                default:              wr = 1'b0;
            endcase
        end
        // beq when equal, bne when not
        if (w[6:0] == 7'h63 && w[14:13] == 2'b00 && ((a == b) != w[12])) begin
            rd_e.valid = 1'b1;
            rd_e.pc    = p.pc + off;
            exp_redir.push_back(rd_e);
            flush_next  = 1'b1;
            redir_block = edge_cnt + 3;
        end
        if (wr && w[11:7] != 5'd0) begin
            xreg[w[11:7]]    = res;
            free_at[w[11:7]] = edge_cnt + 4;
            wb_e.valid       = 1'b1;
            wb_e.rd          = w[11:7];
            wb_e.value       = res;
            exp_wb.push_back(wb_e);
        end
    endtask

    task automatic check_wb(input wb_pkt_t got);
        wb_pkt_t exp;
        if (exp_wb.size() == 0) begin
            stop_run($sformatf("unexpected write-back to x%0d at %0t", got.rd, $time));
        end else begin
            exp = exp_wb.pop_front();
            if (got.rd !== exp.rd) begin
                stop_run($sformatf("ERR %0t wb_o.rd expected %0d got %0d",
                                   $time, exp.rd, got.rd));
            end else if (got.value !== exp.value) begin
                stop_run($sformatf("ERR %0t wb_o.value expected %h got %h",
                                   $time, exp.value, got.value));
            end
        end
    endtask

    task automatic check_redirect(input redirect_t got);
        redirect_t exp;
        if (exp_redir.size() == 0) begin
            stop_run($sformatf("unexpected redirect to %h at %0t", got.pc, $time));
        end else begin
            exp = exp_redir.pop_front();
            if (got.pc !== exp.pc) begin
                stop_run($sformatf("ERR %0t redirect_o.pc expected %h got %h",
                                   $time, exp.pc, got.pc));
            end
        end
    endtask

    task automatic check_ready(input logic exp, input logic got);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t inst_ready_o expected %b got %b", $time, exp, got));
        end
    endtask

    task automatic watchdog();
        #((stim_q.size() * 20 + 10) * CLK_NS);
        stop_run("watchdog expired before the instruction table was done");
    endtask

    always @(negedge clk) begin
        if (!reset && wb.valid) begin
            check_wb(wb);
        end
        if (!reset && redirect.valid) begin
            check_redirect(redirect);
        end
    end

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        void'($urandom(32'h03df_3e36));
        build_table();
        fork
            watchdog();
        join_none
        @(negedge reset);
        @(posedge clk);
        #1;
        foreach (stim_q[i]) begin
            inst_valid = 1'b1;
            inst       = stim_q[i];
            do begin
                @(negedge clk);
                check_ready(ready_model(stim_q[i].inst), inst_ready);
                if (!inst_ready) begin
                    flush_next = 1'b0;
                end
            end while (!inst_ready);
            // squashed when right behind a taken branch
            if (flush_next) begin
                flush_next = 1'b0;
            end else begin
                run_model(stim_q[i]);
            end
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b0;
        // last result is out two edges after acceptance
        repeat (3) @(posedge clk);
        if (exp_wb.size() != 0 || exp_redir.size() != 0) begin
            stop_run($sformatf("missing results, %0d write-backs and %0d redirects never seen",
                               exp_wb.size(), exp_redir.size()));
        end else begin
            run_done = 1'b1;
            $display(">>> PASS");
            $finish;
        end
    end

    final begin
        if (!run_done) begin
            $display(">>> FAIL");
        end
    end

endmodule

/* compile.f */
+incdir+logic
logic/kiwi_pkg.sv
logic/kiwi_decoder.sv
logic/kiwi_regfile.sv
logic/kiwi_alu.sv
logic/kiwi_beu.sv
logic/kiwi_scoreboard.sv
logic/kiwi_core.sv
tb/kiwi_clock_gen.sv
tb/kiwi_properties.sv
tb/kiwi_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= kiwi_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "test failed, no verdict in log"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
